// ==== common/core_pkg.sv ====
package core_pkg;

    ////////////////////
    // widths

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  imm8_t;

    // data-processing command field, instruction bits 24:21
    typedef enum logic [3:0] {
        cmd_and = 4'b0000,
        cmd_eor = 4'b0001,
        cmd_sub = 4'b0010,
        cmd_add = 4'b0100,
        cmd_orr = 4'b1100,
        cmd_mov = 4'b1101
    } alu_cmd_t;

    ////////////////////
    // constants

    localparam word_t     pc_step        = 32'd4;
    localparam word_t     pc_read_offset = 32'd8;
    localparam reg_addr_t reg_pc         = 4'd15;

    // op field of the data-processing format
    localparam logic [1:0] op_data_proc = 2'b00;

    // op field 2'b11, so it decodes as a no-op
    localparam word_t nop_instr = 32'h0c00_0000;

    ////////////////////
    // stage payloads

    // decode to execute
    typedef struct packed {
        logic      valid;
        alu_cmd_t  cmd;
        logic      use_imm;
        reg_addr_t rn_addr;
        reg_addr_t rm_addr;
        word_t     rn_val;
        word_t     rm_val;
        word_t     imm;
        reg_addr_t rd;
    } ex_bundle_t;

    // memory stage and writeback results
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

// ==== fetch/fetch_unit.sv ====
module fetch_unit #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::word_t instr,
    output core_pkg::word_t pc,
    output core_pkg::word_t instr_f,
    output core_pkg::word_t pc_f
);
    import core_pkg::*;

    // program counter, no branches so it only steps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc + pc_step;
        end
    end

    // fetch/decode register, word and its address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_f <= nop_instr;
            pc_f    <= '0;
        end else begin
            instr_f <= instr;
            pc_f    <= pc;
        end
    end

endmodule

// ==== decode/reg_file.sv ====
module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::retire_t  wr,
    input  core_pkg::reg_addr_t ra1,
    input  core_pkg::reg_addr_t ra2,
    input  core_pkg::word_t    pc_read,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2
);
    import core_pkg::*;

    // r0..r14, r15 is the pc
    word_t regs [0:14];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != reg_pc) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // write-first, so a same-cycle write is visible
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == reg_pc) begin
            return pc_read;
        end else if (wr.valid && wr.rd == addr) begin
            return wr.data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

// ==== decode/decode_stage.sv ====
module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::word_t      instr_f,
    input  core_pkg::word_t      pc_f,
    input  core_pkg::retire_t    wb,
    output core_pkg::ex_bundle_t ex
);
    import core_pkg::*;

    ////////////////////
    // field split

    logic [1:0] op;
    logic       use_imm;
    alu_cmd_t   cmd;
    reg_addr_t  rn;
    reg_addr_t  rd;
    reg_addr_t  rm;
    imm8_t      imm8;

    logic       cmd_ok;
    logic       dec_valid;
    word_t      pc_read;
    word_t      rn_val;
    word_t      rm_val;

    ex_bundle_t ex_next;
    ex_bundle_t ex_q;
    logic       valid_q;

    // cond field 31:28 and S bit 20 are ignored
    assign op      = instr_f[27:26];
    assign use_imm = instr_f[25];
    assign cmd     = alu_cmd_t'(instr_f[24:21]);
    assign rn      = instr_f[19:16];
    assign rd      = instr_f[15:12];
    assign imm8    = instr_f[7:0];
    assign rm      = instr_f[3:0];

    always_comb begin
        case (cmd)
            cmd_and, cmd_eor, cmd_sub, cmd_add, cmd_orr, cmd_mov: cmd_ok = 1'b1;
            default: cmd_ok = 1'b0;
        endcase
    end

    // writes to r15 would be branches, so they retire nothing
    assign dec_valid = (op == op_data_proc) && cmd_ok && (rd != reg_pc);

    // r15 reads as the instruction address plus eight
    assign pc_read = pc_f + pc_read_offset;

    ////////////////////
    // operand read

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .wr      (wb),
        .ra1     (rn),
        .ra2     (rm),
        .pc_read (pc_read),
        .rd1     (rn_val),
        .rd2     (rm_val)
    );

    always_comb begin
        ex_next.valid   = dec_valid;
        ex_next.cmd     = cmd;
        ex_next.use_imm = use_imm;
        ex_next.rn_addr = rn;
        ex_next.rm_addr = rm;
        ex_next.rn_val  = rn_val;
        ex_next.rm_val  = rm_val;
        // zero-extended 8-bit immediate
        ex_next.imm     = {24'd0, imm8};
        ex_next.rd      = rd;
    end

    ////////////////////
    // decode/execute register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex_next.valid;
        end
    end

    // payload, qualified by valid_q
    always_ff @(posedge clk) begin
        ex_q <= ex_next;
    end

    always_comb begin
        ex       = ex_q;
        ex.valid = valid_q;
    end

endmodule

// ==== execute/alu.sv ====
module alu (
    input  core_pkg::alu_cmd_t cmd,
    input  core_pkg::word_t    a,
    input  core_pkg::word_t    b,
    output core_pkg::word_t    y
);
    import core_pkg::*;

    // no flags, all results wrap at 32 bits
    always_comb begin
        case (cmd)
            cmd_and: begin
                y = a & b;
            end
            cmd_eor: begin
                y = a ^ b;
            end
            cmd_sub: begin
                y = a - b;
            end
            cmd_add: begin
                y = a + b;
            end
            cmd_orr: begin
                y = a | b;
            end
            // mov passes the second operand
            cmd_mov: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::ex_bundle_t ex,
    output core_pkg::retire_t    wb_out
);
    import core_pkg::*;

    retire_t mem_fwd;
    retire_t mem_next;
    retire_t mem_q;
    retire_t wb_q;
    logic    mem_valid;
    logic    wb_valid;

    word_t   src_a;
    word_t   rm_fwd;
    word_t   src_b;
    word_t   alu_y;

    ////////////////////
    // forwarding

    // newest producer wins, memory stage before writeback
    function automatic word_t fwd_sel(
        input reg_addr_t addr,
        input word_t     dec_val,
        input retire_t   m,
        input retire_t   w
    );
        if (addr == reg_pc) begin
            return dec_val;
        end else if (m.valid && m.rd == addr) begin
            return m.data;
        end else if (w.valid && w.rd == addr) begin
            return w.data;
        end else begin
            return dec_val;
        end
    endfunction

    always_comb begin
        src_a  = fwd_sel(ex.rn_addr, ex.rn_val, mem_fwd, wb_out);
        rm_fwd = fwd_sel(ex.rm_addr, ex.rm_val, mem_fwd, wb_out);
        src_b  = ex.use_imm ? ex.imm : rm_fwd;
    end

    alu u_alu (
        .cmd (ex.cmd),
        .a   (src_a),
        .b   (src_b),
        .y   (alu_y)
    );

    always_comb begin
        mem_next.valid = ex.valid;
        mem_next.rd    = ex.rd;
        mem_next.data  = alu_y;
    end

    ////////////////////
    // memory stage

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= mem_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_q <= mem_next;
    end

    always_comb begin
        mem_fwd       = mem_q;
        mem_fwd.valid = mem_valid;
    end

    ////////////////////
    // writeback stage

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_fwd.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= mem_fwd;
    end

    // retire port and register file write
    always_comb begin
        wb_out       = wb_q;
        wb_out.valid = wb_valid;
    end

endmodule

// ==== source/core_top.sv ====
module core_top #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::word_t   instr,
    output core_pkg::word_t   pc,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    word_t      instr_f;
    word_t      pc_f;
    ex_bundle_t ex_bundle;

    ////////////////////
    // fetch

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .pc      (pc),
        .instr_f (instr_f),
        .pc_f    (pc_f)
    );

    ////////////////////
    // decode

    // writeback result loops back into the register file
    decode_stage u_decode (
        .clk     (clk),
        .reset   (reset),
        .instr_f (instr_f),
        .pc_f    (pc_f),
        .wb      (retire),
        .ex      (ex_bundle)
    );

    ////////////////////
    // execute, memory, writeback

    execute_stage u_execute (
        .clk    (clk),
        .reset  (reset),
        .ex     (ex_bundle),
        .wb_out (retire)
    );

endmodule

// ==== verification/core_assertions.sv ====
module core_assertions #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input logic              clk,
    input logic              reset,
    input core_pkg::word_t   pc,
    input core_pkg::word_t   instr,
    input core_pkg::retire_t retire
);
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_rec_t;

    int         error_count = 0;
    int         retire_count;
    logic       started;
    word_t      last_pc;
    fetch_rec_t line [0:3];
    word_t      shadow [0:15];

    fetch_rec_t rec;
    logic       cmd_known;
    logic       exp_valid;
    reg_addr_t  exp_rd;
    reg_addr_t  src_n;
    reg_addr_t  src_m;
    word_t      op_a;
    word_t      op_b;
    word_t      exp_data;

    function automatic word_t apply_command(input logic [3:0] c, input word_t a, input word_t b);
        case (c)
            cmd_and: return a & b;
            cmd_eor: return a ^ b;
            cmd_sub: return a - b;
            cmd_add: return a + b;
            cmd_orr: return a | b;
            default: return b;
        endcase
    endfunction

    ////////////////////
    // reference model

    // four edges between fetch and the retire check
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            started      <= 1'b0;
            last_pc      <= '0;
            retire_count <= 0;
            for (int i = 0; i < 4; i++) begin
                line[i] <= '0;
            end
            for (int i = 0; i < 16; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            started <= 1'b1;
            last_pc <= pc;
            line[0] <= '{valid: 1'b1, pc: pc, instr: instr};
            for (int i = 1; i < 4; i++) begin
                line[i] <= line[i - 1];
            end
            if (retire.valid) begin
                retire_count <= retire_count + 1;
            end
            // shadow follows the model, in program order
            if (exp_valid) begin
                shadow[exp_rd] <= exp_data;
            end
        end
    end

    always_comb begin
        rec    = line[3];
        exp_rd = rec.instr[15:12];
        src_n  = rec.instr[19:16];
        src_m  = rec.instr[3:0];
        case (rec.instr[24:21])
            cmd_and, cmd_eor, cmd_sub, cmd_add, cmd_orr, cmd_mov: cmd_known = 1'b1;
            default: cmd_known = 1'b0;
        endcase
        exp_valid = rec.valid && (rec.instr[27:26] == 2'b00) && cmd_known && (exp_rd != reg_pc);
        op_a = (src_n == reg_pc) ? rec.pc + pc_read_offset : shadow[src_n];
        if (rec.instr[25]) begin
            op_b = {24'd0, rec.instr[7:0]};
        end else begin
            op_b = (src_m == reg_pc) ? rec.pc + pc_read_offset : shadow[src_m];
        end
        exp_data = apply_command(rec.instr[24:21], op_a, op_b);
    end

    ////////////////////
    // checks

    a_first_pc: assert property (@(posedge clk) disable iff (reset)
        !started |-> (pc == reset_pc))
    else begin
        error_count = error_count + 1;
        $error("Mismatch pc: got %h, expected %h", $sampled(pc), reset_pc);
    end

    a_pc_step: assert property (@(posedge clk) disable iff (reset)
        started |-> (pc == last_pc + pc_step))
    else begin
        error_count = error_count + 1;
        $error("Mismatch pc: got %h, expected %h", $sampled(pc), $sampled(last_pc) + pc_step);
    end

    a_retire_valid: assert property (@(posedge clk) disable iff (reset)
        retire.valid == exp_valid)
    else begin
        error_count = error_count + 1;
        $error("Mismatch retire.valid: got %h, expected %h",
            $sampled(retire.valid), $sampled(exp_valid));
    end

    a_retire_rd: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && exp_valid) |-> (retire.rd == exp_rd))
    else begin
        error_count = error_count + 1;
        $error("Mismatch retire.rd: got %h, expected %h", $sampled(retire.rd), $sampled(exp_rd));
    end

    a_retire_data: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && exp_valid) |-> (retire.data == exp_data))
    else begin
        error_count = error_count + 1;
        $error("Mismatch retire.data: got %h, expected %h",
            $sampled(retire.data), $sampled(exp_data));
    end

endmodule

bind core_top core_assertions #(
    .reset_pc (reset_pc)
) u_core_assertions (
    .clk    (clk),
    .reset  (reset),
    .pc     (pc),
    .instr  (instr),
    .retire (retire)
);

// ==== verification/core_tb.sv ====
module core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int          clk_period     = 40;
    localparam int          reset_cycles   = 8;
    localparam int          run_instrs     = 200;
    localparam int          drain_cycles   = 8;
    localparam int          timeout_cycles = reset_cycles + run_instrs + 20;
    localparam int          drive_delay    = 1;
    localparam int          rom_words      = 256;
    localparam logic [31:0] seed           = 32'hde20_ec61;
    localparam word_t       start_pc       = 32'h0000_0040;

    logic    clk;
    logic    reset;
    word_t   instr;
    word_t   pc;
    retire_t retire;

    word_t   rom [0:rom_words-1];

    core_top #(
        .reset_pc (start_pc)
    ) i_core_top (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // mostly r0..r3 with one in eight being r15
    function automatic reg_addr_t pick_reg(input logic [7:0] r);
        if (r[2:0] == 3'd0) begin
            return r[6:3];
        end else if (r[2:0] == 3'd1) begin
            return reg_pc;
        end else begin
            return {2'b00, r[4:3]};
        end
    endfunction

    function automatic logic [3:0] legal_cmd(input logic [2:0] k);
        case (k)
            3'd0: return cmd_and;
            3'd1: return cmd_eor;
            3'd2: return cmd_sub;
            3'd3: return cmd_add;
            3'd4: return cmd_orr;
            default: return cmd_mov;
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] s;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [1:0]  op;
        logic [3:0]  cmd;
        logic [11:0] operand;
        s = seed;
        for (int i = 0; i < rom_words; i++) begin
            s  = next_random(s);
            r1 = s;
            s  = next_random(s);
            r2 = s;
            // a few words outside the data-processing format or command set
            if (r1[3:0] != 4'd0) begin
                op = 2'b00;
            end else if (r1[18:17] == 2'b00) begin
                op = 2'b01;
            end else begin
                op = r1[18:17];
            end
            cmd = (r1[7:5] == 3'd0) ? r1[11:8] : legal_cmd(r1[14:12]);
            operand = r1[15] ? {4'h0, r2[31:24]} : {8'h00, pick_reg(r2[23:16])};
            rom[i] = {4'he, op, r1[15], cmd, r1[16], pick_reg(r2[7:0]),
                pick_reg(r2[15:8]), operand};
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // instruction ROM answers pc just after each edge
    initial begin
        instr = '0;
        forever begin
            @(posedge clk);
            #drive_delay;
            instr = rom[pc[9:2]];
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("Run timed out after %0d clock cycles", timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int errors;
        int retired;
        reset = 1'b1;
        build_program();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        repeat (run_instrs + drain_cycles) @(posedge clk);
        #drive_delay;
        errors  = i_core_top.u_core_assertions.error_count;
        retired = i_core_top.u_core_assertions.retire_count;
        if (retired == 0) begin
            $display("No instruction retired during the run");
        end
        $display("Run finished: %0d instructions retired, %0d errors", retired, errors);
        if (errors == 0 && retired > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/core_pkg.sv
fetch/fetch_unit.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
source/core_top.sv
verification/core_assertions.sv
verification/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module core_tb -f flist.f -o core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# keep running past the first assertion error so the closing report prints
output=$(./obj_dir/core_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
